// ==== Makefile ====
TOP := operator_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -f list.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== list.f ====
logic/opl3_pkg.sv
logic/sample_clk_gen.sv
logic/phase_generator.sv
logic/envelope_generator.sv
logic/waveform_generator.sv
logic/operator.sv
logic/operator_top.sv
testbench/operator_properties.sv
testbench/operator_tb.sv

// ==== logic/envelope_generator.sv ====
`timescale 1ns/1ps

module envelope_generator (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           sample_clk_en,
    input  logic                           key_on,
    input  logic                           kon,
    input  opl3_pkg::operator_regs_t       regs,
    output logic [opl3_pkg::ENV_WIDTH-1:0] att
);
    import opl3_pkg::*;

    env_state_t           state;
    env_state_t           state_next;
    logic [ENV_WIDTH-1:0] env;              // 0 loudest, ENV_MAX silent
    logic [ENV_WIDTH-1:0] env_next;
    logic [ENV_WIDTH-1:0] attack_step;      // ar * 4
    logic [ENV_WIDTH-1:0] decay_cap;        // sl * 32
    logic [ENV_WIDTH:0]   env_plus_dr;      // extra bit for carry
    logic [ENV_WIDTH:0]   env_plus_rr;
    logic [ENV_WIDTH:0]   env_plus_tl;
    logic [ENV_WIDTH-1:0] env_rr_sat;

    always_comb begin
        attack_step = ENV_WIDTH'({regs.ar, 2'b00});
        decay_cap   = (regs.sl == '1) ? ENV_MAX : {regs.sl, 5'b00000};  // sl 15 means full scale
        env_plus_dr = {1'b0, env} + (ENV_WIDTH + 1)'(regs.dr);
        env_plus_rr = {1'b0, env} + (ENV_WIDTH + 1)'(regs.rr);
        env_plus_tl = {1'b0, env} + (ENV_WIDTH + 1)'({regs.tl, 2'b00});
        env_rr_sat  = env_plus_rr[ENV_WIDTH] ? ENV_MAX : env_plus_rr[ENV_WIDTH-1:0];
        att         = env_plus_tl[ENV_WIDTH] ? ENV_MAX : env_plus_tl[ENV_WIDTH-1:0];
    end

    // next state, priority: key-on, key-off, then per-state step
    always_comb begin
        state_next = state;
        env_next   = env;
        if (key_on) begin
            state_next = ENV_ATTACK;                    // env left where it is
        end else if (!kon && state != ENV_RELEASE && state != ENV_IDLE) begin
            state_next = ENV_RELEASE;
        end else begin
            case (state)
                ENV_ATTACK: begin
                    if (regs.ar == '1 || env <= attack_step) begin
                        env_next = '0;                  // instant or floored
                    end else begin
                        env_next = env - attack_step;
                    end
                    if (env_next == '0) begin
                        state_next = ENV_DECAY;
                    end
                end
                ENV_DECAY: begin
                    if (env_plus_dr >= {1'b0, decay_cap}) begin
                        env_next   = decay_cap;         // clamp at sustain level
                        state_next = ENV_SUSTAIN;
                    end else begin
                        env_next = env_plus_dr[ENV_WIDTH-1:0];
                    end
                end
                ENV_SUSTAIN: begin
                    if (!regs.egt) begin
                        env_next = env_rr_sat;          // percussive, keeps fading
                    end
                end
                ENV_RELEASE: begin
                    env_next = env_rr_sat;
                    if (env_next == ENV_MAX) begin
                        state_next = ENV_IDLE;
                    end
                end
                ENV_IDLE: begin
                    env_next = env;                     // silent until key-on
                end
                default: begin
                    state_next = ENV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ENV_IDLE;
            env   <= ENV_MAX;
        end else if (sample_clk_en) begin
            state <= state_next;
            env   <= env_next;
        end
    end

endmodule

// ==== logic/operator.sv ====
`timescale 1ns/1ps

module operator (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     sample_clk_en,
    input  logic                                     kon,
    input  opl3_pkg::operator_regs_t                 regs,
    output logic signed [opl3_pkg::OP_OUT_WIDTH-1:0] out,
    output logic                                     out_valid
);
    import opl3_pkg::*;

    logic                   kon_q;      // kon seen at the previous tick
    logic                   key_on;     // rising kon, one tick wide
    logic [PHASE_WIDTH-1:0] phase;
    logic [ENV_WIDTH-1:0]   att;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kon_q <= 1'b0;
        end else if (sample_clk_en) begin
            kon_q <= kon;
        end
    end

    assign key_on = sample_clk_en && kon && !kon_q;

    phase_generator u_phase (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .key_on        (key_on),
        .regs          (regs),
        .phase         (phase)
    );

    envelope_generator u_env (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .key_on        (key_on),
        .kon           (kon),
        .regs          (regs),
        .att           (att)
    );

    waveform_generator u_wave (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .phase         (phase),
        .att           (att),
        .ws            (regs.ws),
        .out           (out),
        .out_valid     (out_valid)
    );

endmodule

// ==== logic/operator_top.sv ====
`timescale 1ns/1ps

module operator_top (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     kon,
    input  opl3_pkg::operator_regs_t                 regs,
    output logic signed [opl3_pkg::OP_OUT_WIDTH-1:0] out,
    output logic                                     out_valid
);
    logic sample_clk_en;    // one pulse per sample period

    sample_clk_gen u_sample_clk (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en)
    );

    operator u_op (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .kon           (kon),
        .regs          (regs),
        .out           (out),
        .out_valid     (out_valid)
    );

endmodule

// ==== logic/opl3_pkg.sv ====
package opl3_pkg;

    localparam int SAMPLE_DIV        = 8;                   // clocks per sample tick
    localparam int SAMPLE_CNT_WIDTH  = $clog2(SAMPLE_DIV);
    localparam int PHASE_WIDTH       = 19;

    // register field widths
    localparam int FNUM_WIDTH        = 10;
    localparam int BLOCK_WIDTH       = 3;
    localparam int MULT_WIDTH        = 4;
    localparam int WS_WIDTH          = 2;
    localparam int REG_ENV_WIDTH     = 4;                   // ar, dr, sl, rr
    localparam int TL_WIDTH          = 6;
    localparam int MULT_FACTOR_WIDTH = 5;                   // holds 2x multiplier, max 30

    localparam int ENV_WIDTH         = 9;
    localparam logic [ENV_WIDTH-1:0] ENV_MAX = '1;          // 511, silent

    localparam int ROM_DEPTH         = 32;                  // quarter-wave entries
    localparam int ROM_ADDR_WIDTH    = $clog2(ROM_DEPTH);
    localparam int ROM_WIDTH         = 12;
    localparam int OP_OUT_WIDTH      = 13;                  // signed sample

    typedef struct packed {
        logic [FNUM_WIDTH-1:0]    fnum;
        logic [BLOCK_WIDTH-1:0]   block;                    // octave
        logic [MULT_WIDTH-1:0]    mult;
        logic [WS_WIDTH-1:0]      ws;                       // waveform select
        logic [REG_ENV_WIDTH-1:0] ar;
        logic [REG_ENV_WIDTH-1:0] dr;
        logic [REG_ENV_WIDTH-1:0] sl;
        logic [REG_ENV_WIDTH-1:0] rr;
        logic [TL_WIDTH-1:0]      tl;                       // total level, 4 env steps each
        logic                     egt;                      // 1 = hold at sustain
    } operator_regs_t;

    typedef enum logic [2:0] {
        ENV_ATTACK,
        ENV_DECAY,
        ENV_SUSTAIN,
        ENV_RELEASE,
        ENV_IDLE
    } env_state_t;

    // twice the real multiplier, so mult 0 (x0.5) stays an integer
    function automatic logic [MULT_FACTOR_WIDTH-1:0] mult_factor(
        input logic [MULT_WIDTH-1:0] mult
    );
        logic [MULT_FACTOR_WIDTH-1:0] factor;
        case (mult)
            4'd0:         factor = 5'd1;
            4'd11:        factor = 5'd20;
            4'd12, 4'd13: factor = 5'd24;
            4'd14, 4'd15: factor = 5'd30;
            default:      factor = {mult, 1'b0};    // 1..10 map to 2*mult
        endcase
        return factor;
    endfunction

endpackage

// ==== logic/phase_generator.sv ====
`timescale 1ns/1ps

module phase_generator (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             sample_clk_en,
    input  logic                             key_on,
    input  opl3_pkg::operator_regs_t         regs,
    output logic [opl3_pkg::PHASE_WIDTH-1:0] phase
);
    import opl3_pkg::*;

    localparam int SHIFT_WIDTH = FNUM_WIDTH + 2**BLOCK_WIDTH - 1;  // fnum << 7 worst case
    localparam int PROD_WIDTH  = SHIFT_WIDTH + MULT_FACTOR_WIDTH;

    logic [SHIFT_WIDTH-1:0] fnum_shifted;   // fnum scaled by octave
    logic [PROD_WIDTH-1:0]  freq_prod;      // times 2x multiplier
    logic [PHASE_WIDTH-1:0] phase_inc;

    always_comb begin
        fnum_shifted = SHIFT_WIDTH'(regs.fnum) << regs.block;
        freq_prod    = PROD_WIDTH'(fnum_shifted) * PROD_WIDTH'(mult_factor(regs.mult));
        // drop the extra factor of two; bits above PHASE_WIDTH vanish mod 2^N anyway
        phase_inc    = PHASE_WIDTH'(freq_prod >> 1);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (sample_clk_en) begin
            if (key_on) begin
                phase <= '0;                    // note starts at zero phase
            end else begin
                phase <= phase + phase_inc;     // wraps naturally
            end
        end
    end

endmodule

// ==== logic/sample_clk_gen.sv ====
`timescale 1ns/1ps

module sample_clk_gen (
    input  logic clk,
    input  logic rst_n,
    output logic sample_clk_en
);
    import opl3_pkg::*;

    logic [SAMPLE_CNT_WIDTH-1:0] cnt;   // position within sample period

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt           <= '0;
            sample_clk_en <= 1'b0;
        end else begin
            if (cnt == SAMPLE_CNT_WIDTH'(SAMPLE_DIV - 1)) begin
                cnt <= '0;                  // wrap
            end else begin
                cnt <= cnt + 1'b1;
            end
            sample_clk_en <= (cnt == SAMPLE_CNT_WIDTH'(SAMPLE_DIV - 2));  // registered terminal count
        end
    end

endmodule

// ==== logic/sine_rom.hex ====
// one column: 12-bit amplitude, entry i = 4095 * sin((2i+1) * pi / 128)
064
12D
1F5
2BC
381
444
505
5C2
67B
731
7E2
88F
936
9D7
A73
B08
B96
C1D
C9C
D14
D84
DEB
E4A
EA0
EED
F30
F6B
F9B
FC3
FE0
FF4
FFE

// ==== logic/waveform_generator.sv ====
`timescale 1ns/1ps

module waveform_generator (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     sample_clk_en,
    input  logic [opl3_pkg::PHASE_WIDTH-1:0]         phase,
    input  logic [opl3_pkg::ENV_WIDTH-1:0]           att,
    input  logic [opl3_pkg::WS_WIDTH-1:0]            ws,
    output logic signed [opl3_pkg::OP_OUT_WIDTH-1:0] out,
    output logic                                     out_valid
);
    import opl3_pkg::*;

    logic [ROM_WIDTH-1:0]             sine_rom [ROM_DEPTH];   // first quarter of sine
    logic                             tick_q;                 // phase/att updated last cycle
    logic [WS_WIDTH-1:0]              ws_q;                   // ws latched at the tick
    logic [1:0]                       quadrant;
    logic [ROM_ADDR_WIDTH-1:0]        rom_idx;
    logic signed [ROM_WIDTH:0]        mag;                    // quarter wave, always positive
    logic signed [ROM_WIDTH:0]        wave;
    logic signed [ROM_WIDTH:0]        wave_s1;
    logic [ENV_WIDTH-1:0]             att_s1;
    logic                             valid_s1;
    logic signed [ENV_WIDTH:0]        gain;                   // 511 - att, as signed
    logic signed [ROM_WIDTH+ENV_WIDTH+1:0] product;

    initial begin
        $readmemh("logic/sine_rom.hex", sine_rom);
    end

    always_comb begin
        quadrant = phase[PHASE_WIDTH-1 -: 2];
        rom_idx  = phase[PHASE_WIDTH-3 -: ROM_ADDR_WIDTH];
        if (quadrant[0]) begin
            rom_idx = ~rom_idx;                 // 31 - i, falling quarters mirrored
        end
        mag = signed'({1'b0, sine_rom[rom_idx]});
        case (ws_q)
            2'd0:    wave = quadrant[1] ? -mag : mag;       // full sine
            2'd1:    wave = quadrant[1] ? '0 : mag;         // half sine
            2'd2:    wave = mag;                            // abs sine
            default: wave = quadrant[0] ? '0 : mag;         // pulse-like quarters
        endcase
        gain    = signed'({1'b0, ENV_MAX - att_s1});
        product = wave_s1 * gain;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_q    <= 1'b0;
            valid_s1  <= 1'b0;
            out_valid <= 1'b0;
            out       <= '0;
        end else begin
            tick_q    <= sample_clk_en;
            valid_s1  <= tick_q;                                    // stage 1 valid
            out_valid <= valid_s1;                                  // stage 2 pulse
            if (valid_s1) begin
                out <= OP_OUT_WIDTH'(product >>> ENV_WIDTH);        // linear attenuation
            end
        end
    end

    // stage 1 payload
    always_ff @(posedge clk) begin
        if (sample_clk_en) begin
            ws_q <= ws;
        end
        wave_s1 <= wave;
        att_s1  <= att;                         // travels with its wave
    end

endmodule

// ==== testbench/operator_properties.sv ====
`timescale 1ns/1ps

module operator_properties (
    input logic clk,
    input logic rst_n,
    input logic sample_clk_en,
    input logic out_valid
);

    // tick, stage 1, stage 2
    valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(sample_clk_en, 3))
        else $error("out_valid is not sample_clk_en delayed by 3 cycles");

    tick_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        sample_clk_en |=> !sample_clk_en)
        else $error("sample_clk_en high on two consecutive cycles");

    // sync reset clears the pulse one edge later
    valid_low_in_reset: assert property (@(posedge clk)
        !rst_n |=> !out_valid)
        else $error("out_valid high while rst_n is low");

endmodule

bind operator operator_properties u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .sample_clk_en (sample_clk_en),
    .out_valid     (out_valid)
);

// ==== testbench/operator_tb.sv ====
`timescale 1ns/1ps

module operator_tb;
    import opl3_pkg::*;

    localparam int     CLK_HALF_NS  = 20;
    localparam int     RESET_CYCLES = 5;
    localparam int     WAIT_LIMIT   = 4 * SAMPLE_DIV;          // cycles allowed per sample
    localparam int     SILENT       = 511;
    localparam longint PHASE_MOD    = longint'(1) << PHASE_WIDTH;

    typedef struct packed {
        operator_regs_t regs;
        logic           kon;
        logic           rand_freq;                             // fnum/block/mult from lcg
        logic [15:0]    samples;
    } stim_row_t;

    logic                           clk;
    logic                           rst_n;
    logic                           kon;
    operator_regs_t                 regs;
    logic signed [OP_OUT_WIDTH-1:0] out;
    logic                           out_valid;

    stim_row_t            stim [$];
    logic [ROM_WIDTH-1:0] ref_rom [ROM_DEPTH];                 // own copy of the quarter wave
    logic [31:0]          lcg_state;

    logic [PHASE_WIDTH-1:0] m_phase;                           // reference model state
    int                     m_env;
    env_state_t             m_state;
    logic                   m_kon_q;

    operator_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .kon       (kon),
        .regs      (regs),
        .out       (out),
        .out_valid (out_valid)
    );

    initial clk = 1'b0;
    always #CLK_HALF_NS clk = ~clk;                            // 40 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic stim_row_t make_row(
        input int fnum,
        input int block,
        input int mult,
        input int ws,
        input int ar,
        input int dr,
        input int sl,
        input int rr,
        input int tl,
        input int egt,
        input int key,
        input int rnd,
        input int samples
    );
        stim_row_t row;
        row.regs.fnum  = FNUM_WIDTH'(fnum);
        row.regs.block = BLOCK_WIDTH'(block);
        row.regs.mult  = MULT_WIDTH'(mult);
        row.regs.ws    = WS_WIDTH'(ws);
        row.regs.ar    = REG_ENV_WIDTH'(ar);
        row.regs.dr    = REG_ENV_WIDTH'(dr);
        row.regs.sl    = REG_ENV_WIDTH'(sl);
        row.regs.rr    = REG_ENV_WIDTH'(rr);
        row.regs.tl    = TL_WIDTH'(tl);
        row.regs.egt   = (egt != 0);
        row.kon        = (key != 0);
        row.rand_freq  = (rnd != 0);
        row.samples    = 16'(samples);
        return row;
    endfunction

    task automatic load_table();
        // fnum blk mult ws  ar dr sl rr  tl egt  kon rnd  samples
        stim.push_back(make_row(300, 4, 1, 0,  1, 1, 1, 1,   0, 1,  0, 0,   6));   // idle, silent
        stim.push_back(make_row(300, 4, 1, 0,  1, 1, 1, 1,   0, 1,  1, 0, 140));   // slow attack
        stim.push_back(make_row(517, 3, 2, 0,  1, 1, 1, 1,   0, 1,  1, 0,  40));   // decay, hold
        stim.push_back(make_row(517, 3, 2, 0,  1, 1, 1, 15,  0, 1,  0, 0,  40));   // fast release
        stim.push_back(make_row(143, 5, 0, 0,  1, 1, 1, 1,   0, 1,  1, 0, 170));   // retrigger
        stim.push_back(make_row(143, 5, 0, 0,  1, 1, 1, 3,   0, 0,  1, 0,  40));   // sustain fade
        stim.push_back(make_row(143, 5, 0, 0,  1, 1, 1, 6,   0, 0,  0, 0,  70));   // down to idle
        stim.push_back(make_row(256, 4, 1, 0, 15, 0, 0, 4,  20, 1,  1, 0, 128));   // full sine
        stim.push_back(make_row(256, 4, 1, 1, 15, 0, 0, 4,  20, 1,  1, 0, 128));   // half sine
        stim.push_back(make_row(256, 4, 1, 2, 15, 0, 0, 4,  20, 1,  1, 0, 128));   // abs sine
        stim.push_back(make_row(256, 4, 1, 3, 15, 0, 0, 4,  20, 1,  1, 0, 128));   // quarter pulses
        for (int n = 0; n < 5; n++) begin
            stim.push_back(make_row(0, 0, 0, 0, 15, 0, 0, 4, 12, 1, 1, 1, 24));    // random freq
        end
    endtask

    // envelope and phase advance for one tick, straight from the register rules
    task automatic model_tick(input operator_regs_t r, input logic k);
        logic   key_on;
        longint inc;
        int     cap;
        key_on  = k && !m_kon_q;
        m_kon_q = k;
        inc = ((longint'(r.fnum) << r.block) * longint'(mult_factor(r.mult))) >> 1;
        if (key_on) begin
            m_phase = '0;                                      // note restart
        end else begin
            m_phase = PHASE_WIDTH'((longint'(m_phase) + inc) % PHASE_MOD);
        end
        if (key_on) begin
            m_state = ENV_ATTACK;
        end else if (!k && m_state != ENV_RELEASE && m_state != ENV_IDLE) begin
            m_state = ENV_RELEASE;
        end else begin
            case (m_state)
                ENV_ATTACK: begin
                    if (int'(r.ar) == 15) begin
                        m_env = 0;
                    end else begin
                        m_env = m_env - 4 * int'(r.ar);
                        if (m_env < 0) begin
                            m_env = 0;
                        end
                    end
                    if (m_env == 0) begin
                        m_state = ENV_DECAY;
                    end
                end
                ENV_DECAY: begin
                    cap   = (int'(r.sl) == 15) ? SILENT : 32 * int'(r.sl);
                    m_env = m_env + int'(r.dr);
                    if (m_env >= cap) begin
                        m_env   = cap;
                        m_state = ENV_SUSTAIN;
                    end
                end
                ENV_SUSTAIN: begin
                    if (!r.egt) begin
                        m_env = (m_env + int'(r.rr) > SILENT) ? SILENT : m_env + int'(r.rr);
                    end
                end
                ENV_RELEASE: begin
                    m_env = (m_env + int'(r.rr) > SILENT) ? SILENT : m_env + int'(r.rr);
                    if (m_env == SILENT) begin
                        m_state = ENV_IDLE;
                    end
                end
                default: begin
                end
            endcase
        end
    endtask

    function automatic logic signed [OP_OUT_WIDTH-1:0] expected_sample(input operator_regs_t r);
        int att;
        int idx;
        int quad;
        int i;
        int mag;
        int wave;
        att = m_env + 4 * int'(r.tl);
        if (att > SILENT) begin
            att = SILENT;
        end
        idx  = int'(m_phase >> (PHASE_WIDTH - 7));             // top 7 phase bits
        quad = idx / 32;
        i    = idx % 32;
        mag  = (quad == 0 || quad == 2) ? int'(ref_rom[ROM_ADDR_WIDTH'(i)])
                                        : int'(ref_rom[ROM_ADDR_WIDTH'(31 - i)]);
        wave = (quad >= 2) ? -mag : mag;
        case (r.ws)
            2'd1:    wave = (quad >= 2) ? 0 : wave;
            2'd2:    wave = mag;
            2'd3:    wave = (quad == 1 || quad == 3) ? 0 : mag;
            default: wave = wave;                              // plain sine
        endcase
        return OP_OUT_WIDTH'((wave * (SILENT - att)) >>> 9);
    endfunction

    task automatic fail_and_stop();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_out(
        input logic signed [OP_OUT_WIDTH-1:0] got,
        input logic signed [OP_OUT_WIDTH-1:0] exp
    );
        if (got !== exp) begin
            $display("ERROR at %0t: out = %0d, expected %0d", $time, got, exp);
            fail_and_stop();
        end
    endtask

    task automatic check_gap(input int got, input int exp);
        if (got != exp) begin
            $display("ERROR at %0t: out_valid gap = %0d cycles, expected %0d", $time, got, exp);
            fail_and_stop();
        end
    endtask

    // counts falling edges up to the next out_valid
    task automatic wait_for_sample(output int cycles);
        logic valid_seen;
        cycles     = 0;
        valid_seen = 1'b0;
        while (!valid_seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            valid_seen = out_valid;
        end
        if (!valid_seen) begin
            $display("no output sample arrived within %0d cycles, time %0t", WAIT_LIMIT, $time);
            fail_and_stop();
        end
    endtask

    initial begin
        int             gap;
        logic           first_pulse;
        stim_row_t      row_cfg;
        operator_regs_t r;
        rst_n       = 1'b0;
        kon         = 1'b0;
        regs        = '0;
        lcg_state   = 32'h1dbf_6f02;
        m_phase     = '0;
        m_env       = SILENT;
        m_state     = ENV_IDLE;
        m_kon_q     = 1'b0;
        first_pulse = 1'b1;
        $readmemh("logic/sine_rom.hex", ref_rom);
        load_table();

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        check_out(out, '0);                                    // cleared by reset

        for (int row = 0; row < stim.size(); row++) begin
            row_cfg = stim[row];
            r       = row_cfg.regs;
            if (row_cfg.rand_freq) begin
                lcg_state = lcg_next(lcg_state);
                r.fnum    = FNUM_WIDTH'(lcg_state >> 22);
                lcg_state = lcg_next(lcg_state);
                r.block   = BLOCK_WIDTH'(lcg_state >> 29);
                lcg_state = lcg_next(lcg_state);
                r.mult    = MULT_WIDTH'(lcg_state >> 28);
            end
            regs = r;                                          // falling edge, between ticks
            kon  = row_cfg.kon;
            for (int s = 0; s < int'(row_cfg.samples); s++) begin
                model_tick(r, row_cfg.kon);
                wait_for_sample(gap);
                if (!first_pulse) begin
                    check_gap(gap, SAMPLE_DIV);
                end
                first_pulse = 1'b0;
                check_out(out, expected_sample(r));
            end
        end

        $display("Testbench passed");
        $finish;
    end

endmodule
